//--- noc_cfg_pkg.sv
package noc_cfg_pkg;

  // --------------------------------------------------
  // Router dimensions
  // --------------------------------------------------
  localparam int NUM_PORTS = 5;                 // L, N, W, S, E
  localparam int NUM_VN    = 3;                 // Virtual networks
  localparam int NUM_VC    = 2;                 // Channels per network
  localparam int NUM_CH    = NUM_VN * NUM_VC;   // Channels per port
  localparam int NUM_REQ   = NUM_CH * NUM_PORTS; // Flat request vector width

  // --------------------------------------------------
  // Identifier types
  // --------------------------------------------------
  typedef logic [4:0] req_id_t;   // Index into the flat request vector
  typedef logic [2:0] ch_id_t;    // Channel, vn * NUM_VC + vc
  typedef logic [1:0] vn_id_t;    // Virtual network
  typedef logic [2:0] port_id_t;  // Input port

  // Owner table entry of a channel that nobody holds
  localparam req_id_t NO_OWNER = 5'd31;

  // Input port order, also the slice order of the request vector
  // Request bit index = port * NUM_CH + channel
  typedef enum logic [2:0] {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_W = 3'd2,
    PORT_S = 3'd3,
    PORT_E = 3'd4
  } port_e;

endpackage

//--- sa_arb_pkg.sv
package sa_arb_pkg;

  // --------------------------------------------------
  // Network weight list
  // --------------------------------------------------
  localparam int WEIGHT_SLOTS = 10;             // Slots walked by the weight pointer

  typedef logic [3:0] weight_ptr_t;             // Enough for slots 0..9

  // Slot k sits at bits 2k+1:2k, one network id per slot
  localparam int WEIGHTS_W = WEIGHT_SLOTS * $bits(noc_cfg_pkg::vn_id_t);

  // Pointer wraps back to slot 0 after this one
  localparam weight_ptr_t LAST_SLOT = weight_ptr_t'(WEIGHT_SLOTS - 1);

  // A slot value of 3 names no network and so never hits

endpackage

//--- rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int WIDTH = 4,
  localparam int ID_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic             clk,
  input  logic             rst_p,
  input  logic [WIDTH-1:0] req,       // Competing requests
  input  logic [WIDTH-1:0] update,    // Accepted grant, zero keeps the pointer
  output logic [WIDTH-1:0] grant,     // Combinational one-hot grant
  output logic [ID_W-1:0]  grant_id   // Index of the granted bit
);

  logic [ID_W-1:0] last;     // Last accepted index
  logic [ID_W-1:0] upd_id;   // Encoded update vector

  // Search starts one past the last accepted index and wraps
  always_comb begin : pick
    int   idx;
    logic found;
    grant    = '0;
    grant_id = '0;
    found    = 1'b0;
    for (int k = 1; k <= WIDTH; k++) begin
      idx = (int'(last) + k) % WIDTH;
      if (!found && req[idx]) begin
        found       = 1'b1;
        grant[idx]  = 1'b1;
        grant_id    = ID_W'(idx);
      end
    end
  end

  always_comb begin
    upd_id = last;
    for (int i = 0; i < WIDTH; i++) begin
      if (update[i]) upd_id = ID_W'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_p) last <= ID_W'(WIDTH - 1);   // Bit 0 has priority after reset
    else if (|update) last <= upd_id;
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst_p) $onehot0(grant));
  a_update_onehot: assert property (@(posedge clk) disable iff (rst_p) $onehot0(update));

endmodule

//--- request_filter.sv
`timescale 1ns/1ps

module request_filter import noc_cfg_pkg::*; (
  input  logic [NUM_REQ-1:0]  req,        // Flat requests, L..E from bit 0 up
  input  req_id_t [NUM_CH-1:0] vc_owner,  // Holder of each downstream channel
  input  logic [NUM_CH-1:0]   stop_go,    // 1 = downstream channel can take a flit
  input  logic                go_phit,    // Output port free for a new flit
  output logic [NUM_REQ-1:0]  req_ok,     // Eligible requests
  output ch_id_t [NUM_REQ-1:0] req_ch     // Downstream channel owned by each request
);

  logic dup_owner;   // Two channels claim the same holder

  for (genvar r = 0; r < NUM_REQ; r++) begin : g_req
    logic [NUM_CH-1:0] match;   // Channels whose owner is this request
    ch_id_t            ch;

    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
      assign match[c] = (vc_owner[c] == req_id_t'(r));
    end

    // At most one bit of match is set, a plain encoder is enough
    always_comb begin
      ch = '0;
      for (int c = 0; c < NUM_CH; c++) begin
        if (match[c]) ch = ch_id_t'(c);
      end
    end

    assign req_ch[r] = ch;
    assign req_ok[r] = req[r] & (|match) & stop_go[ch] & go_phit;  // No channel, no grant
  end

  // --------------------------------------------------
  // Owner table sanity
  // --------------------------------------------------
  always_comb begin
    dup_owner = 1'b0;
    for (int c1 = 0; c1 < NUM_CH; c1++) begin
      for (int c2 = c1 + 1; c2 < NUM_CH; c2++) begin
        if (vc_owner[c1] != NO_OWNER && vc_owner[c1] == vc_owner[c2]) dup_owner = 1'b1;
      end
    end
    a_owner_unique: assert final (!dup_owner)
      else $error("request_filter: one request owns two downstream channels");
  end

endmodule

//--- port_stage.sv
`timescale 1ns/1ps

module port_stage import noc_cfg_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_p,
  input  logic [NUM_REQ-1:0]    req_ok,      // Eligible requests from the filter
  input  logic                  win_valid,   // Some channel wins this cycle
  input  ch_id_t                win_ch,      // Winning channel from vn_stage
  output logic [NUM_CH-1:0]     ch_has_req,  // Channel has at least one port asking
  output port_id_t [NUM_CH-1:0] ch_port      // Port picked for each channel
);

  // --------------------------------------------------
  // One port arbiter per channel
  // --------------------------------------------------
  for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
    logic [NUM_PORTS-1:0] port_req;   // Ports asking for channel c
    logic [NUM_PORTS-1:0] port_gnt;
    logic [NUM_PORTS-1:0] port_upd;
    logic                 ch_won;

    // Channel c of every port, stride NUM_CH in the flat vector
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      assign port_req[p] = req_ok[p * NUM_CH + c];
    end

    assign ch_won   = win_valid && (win_ch == ch_id_t'(c));
    assign port_upd = ch_won ? port_gnt : '0;   // Losing channels keep their pointer

    rr_arbiter #(
      .WIDTH    (NUM_PORTS)
    ) u_port_arb (
      .clk      (clk),
      .rst_p    (rst_p),
      .req      (port_req),
      .update   (port_upd),
      .grant    (port_gnt),
      .grant_id (ch_port[c])
    );

    assign ch_has_req[c] = |port_req;
  end

endmodule

//--- vn_stage.sv
`timescale 1ns/1ps

module vn_stage import noc_cfg_pkg::*, sa_arb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_p,
  input  logic [NUM_CH-1:0]    ch_has_req,  // Channels with a port candidate
  input  logic [WEIGHTS_W-1:0] weights,     // Network weight list
  output logic                 win_valid,   // A channel is granted this cycle
  output ch_id_t               win_ch       // Granted channel
);

  localparam int VN_W = $bits(vn_id_t);

  logic [NUM_VN-1:0][NUM_VC-1:0] vc_gnt;    // Channel grant inside each network
  logic [NUM_VN-1:0][NUM_VC-1:0] vc_upd;
  logic [NUM_VN-1:0]             vc_id;     // One bit, two channels per network
  logic [NUM_VN-1:0]             vn_has;    // Network has a candidate channel
  logic [NUM_VN-1:0]             vn_gnt;    // Fallback network grant
  logic [NUM_VN-1:0]             vn_upd;
  vn_id_t                        vn_rr_id;
  vn_id_t                        w_slot;    // Network named by the current slot
  logic                          w_hit;     // Weighted network can be served
  vn_id_t                        win_vn;
  weight_ptr_t                   wptr;

  // --------------------------------------------------
  // Channel choice inside each network
  // --------------------------------------------------
  for (genvar j = 0; j < NUM_VN; j++) begin : g_vn
    assign vn_has[j] = |ch_has_req[j * NUM_VC +: NUM_VC];
    assign vc_upd[j] = (win_valid && win_vn == vn_id_t'(j)) ? vc_gnt[j] : '0;

    rr_arbiter #(
      .WIDTH    (NUM_VC)
    ) u_vc_arb (
      .clk      (clk),
      .rst_p    (rst_p),
      .req      (ch_has_req[j * NUM_VC +: NUM_VC]),
      .update   (vc_upd[j]),
      .grant    (vc_gnt[j]),
      .grant_id (vc_id[j])
    );
  end

  // --------------------------------------------------
  // Network choice, weight list first
  // --------------------------------------------------
  assign w_slot = weights[wptr * VN_W +: VN_W];
  assign w_hit  = (w_slot < vn_id_t'(NUM_VN)) && vn_has[w_slot];  // Slot 3 never hits

  // Fallback pointer moves only when the weighted network was empty
  assign vn_upd = w_hit ? '0 : vn_gnt;

  rr_arbiter #(
    .WIDTH    (NUM_VN)
  ) u_vn_arb (
    .clk      (clk),
    .rst_p    (rst_p),
    .req      (vn_has),
    .update   (vn_upd),
    .grant    (vn_gnt),
    .grant_id (vn_rr_id)
  );

  assign win_vn    = w_hit ? w_slot : vn_rr_id;
  assign win_valid = |ch_has_req;
  assign win_ch    = ch_id_t'(win_vn * NUM_VC + vc_id[win_vn]);

  // Weight pointer steps once per grant
  always_ff @(posedge clk) begin
    if (rst_p) begin
      wptr <= '0;
    end else if (win_valid) begin
      wptr <= (wptr == LAST_SLOT) ? '0 : wptr + 1'b1;
    end
  end

  a_wptr_range: assert property (@(posedge clk) disable iff (rst_p)
    wptr < weight_ptr_t'(WEIGHT_SLOTS));

endmodule

//--- sa_vc_top.sv
`timescale 1ns/1ps

module sa_vc_top import noc_cfg_pkg::*, sa_arb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_p,
  input  logic [NUM_CH-1:0]    req_e,
  input  logic [NUM_CH-1:0]    req_s,
  input  logic [NUM_CH-1:0]    req_w,
  input  logic [NUM_CH-1:0]    req_n,
  input  logic [NUM_CH-1:0]    req_l,
  input  req_id_t [NUM_CH-1:0] vc_owner,     // Request holding each downstream channel
  input  logic [NUM_CH-1:0]    stop_go,      // Downstream Stop & Go, 1 = go
  input  logic                 go_phit,      // Output port ready for a new flit
  input  logic [WEIGHTS_W-1:0] weights,
  output logic [NUM_REQ-1:0]   grant,        // Registered, one-hot or zero
  output ch_id_t               vc_selected   // Downstream channel of the last grant
);

  logic [NUM_REQ-1:0]    req;
  logic [NUM_REQ-1:0]    req_ok;
  ch_id_t [NUM_REQ-1:0]  req_ch;
  logic [NUM_CH-1:0]     ch_has_req;
  port_id_t [NUM_CH-1:0] ch_port;
  logic                  win_valid;
  ch_id_t                win_ch;
  req_id_t               win_idx;     // Flat index of the winning request
  logic [NUM_REQ-1:0]    grant_next;

  // Port slices in enum order, LOCAL at the bottom
  assign req[PORT_L * NUM_CH +: NUM_CH] = req_l;
  assign req[PORT_N * NUM_CH +: NUM_CH] = req_n;
  assign req[PORT_W * NUM_CH +: NUM_CH] = req_w;
  assign req[PORT_S * NUM_CH +: NUM_CH] = req_s;
  assign req[PORT_E * NUM_CH +: NUM_CH] = req_e;

  request_filter u_filter (
    .req        (req),
    .vc_owner   (vc_owner),
    .stop_go    (stop_go),
    .go_phit    (go_phit),
    .req_ok     (req_ok),
    .req_ch     (req_ch)
  );

  port_stage u_port_stage (
    .clk        (clk),
    .rst_p      (rst_p),
    .req_ok     (req_ok),
    .win_valid  (win_valid),
    .win_ch     (win_ch),
    .ch_has_req (ch_has_req),
    .ch_port    (ch_port)
  );

  vn_stage u_vn_stage (
    .clk        (clk),
    .rst_p      (rst_p),
    .ch_has_req (ch_has_req),
    .weights    (weights),
    .win_valid  (win_valid),
    .win_ch     (win_ch)
  );

  // --------------------------------------------------
  // Grant vector and output registers
  // --------------------------------------------------
  assign win_idx = req_id_t'(ch_port[win_ch] * NUM_CH + win_ch);

  always_comb begin
    grant_next = '0;
    if (win_valid) grant_next[win_idx] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst_p) begin
      grant       <= '0;
      vc_selected <= '0;
    end else begin
      grant <= grant_next;                             // Zero when nothing eligible
      if (win_valid) vc_selected <= req_ch[win_idx];   // Held between grants
    end
  end

  a_grant_eligible: assert property (@(posedge clk) disable iff (rst_p)
    (grant & ~$past(req_ok)) == '0);

endmodule

//--- tb_sa_vc.sv
`timescale 1ns/1ps

module tb_sa_vc import noc_cfg_pkg::*, sa_arb_pkg::*; ();

  localparam int RESET_CYCLES    = 10;
  localparam int DIRECTED_CYCLES = 200;    // Directed tests with reset phases
  localparam int RANDOM_CYCLES   = 1000;
  localparam int TIMEOUT_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + 300;

  logic                 clk = 1'b0;
  logic                 rst_p;
  logic [NUM_CH-1:0]    req_e, req_s, req_w, req_n, req_l;
  req_id_t [NUM_CH-1:0] vc_owner;
  logic [NUM_CH-1:0]    stop_go;
  logic                 go_phit;
  logic [WEIGHTS_W-1:0] weights;
  logic [NUM_REQ-1:0]   grant;
  ch_id_t               vc_selected;

  // Reference model state, mirrors every arbiter pointer
  int                 model_wptr;
  int                 model_port_last [NUM_CH];
  int                 model_vc_last   [NUM_VN];
  int                 model_vn_last;
  logic [NUM_REQ-1:0] exp_grant;
  ch_id_t             exp_vc;
  logic               primed = 1'b0;       // First expectation is ready
  int                 cycle_count = 0;
  integer             seed;
  int                 slot_list [WEIGHT_SLOTS] = '{0, 2, 1, 1, 0, 2, 2, 0, 1, 2};

  sa_vc_top UUT (
    .clk         (clk),
    .rst_p       (rst_p),
    .req_e       (req_e),
    .req_s       (req_s),
    .req_w       (req_w),
    .req_n       (req_n),
    .req_l       (req_l),
    .vc_owner    (vc_owner),
    .stop_go     (stop_go),
    .go_phit     (go_phit),
    .weights     (weights),
    .grant       (grant),
    .vc_selected (vc_selected)
  );

  always #20 clk = ~clk;   // 40 ns cycle

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // First set bit after the last accepted index, ascending order
  function automatic int rr_pick(input int width, input int last, input logic [7:0] bits);
    int idx;
    for (int k = 1; k <= width; k++) begin
      idx = (last + k) % width;
      if (bits[idx]) return idx;
    end
    return 0;
  endfunction

  function automatic logic [NUM_REQ-1:0] expected_grant(output int win_port,
      output int win_ch, output int win_vn, output logic win_hit, output int win_own);
    logic [NUM_REQ-1:0]   req_all;
    logic [NUM_REQ-1:0]   elig;
    logic [NUM_REQ-1:0]   g;
    int                   own [NUM_REQ];
    logic [NUM_CH-1:0]    ch_has;
    logic [NUM_VN-1:0]    vn_has;
    logic [NUM_PORTS-1:0] ports;
    int                   slot;
    int                   vc;
    req_all  = {req_e, req_s, req_w, req_n, req_l};   // LOCAL in the low bits
    g        = '0;
    ch_has   = '0;
    win_port = 0;
    win_ch   = 0;
    win_vn   = 0;
    win_hit  = 1'b0;
    win_own  = 0;
    for (int r = 0; r < NUM_REQ; r++) begin
      own[r]  = -1;
      elig[r] = 1'b0;
      for (int c = 0; c < NUM_CH; c++) begin
        if (int'(vc_owner[c]) == r) own[r] = c;
      end
      if (req_all[r] && own[r] >= 0 && go_phit) elig[r] = stop_go[own[r]];
      if (elig[r]) ch_has[r % NUM_CH] = 1'b1;   // Slot channel of the request
    end
    for (int v = 0; v < NUM_VN; v++) begin
      vn_has[v] = ch_has[v * NUM_VC] | ch_has[v * NUM_VC + 1];
    end
    if (ch_has == '0) return g;   // Nothing eligible
    slot = int'(weights[2 * model_wptr +: 2]);
    if (slot < NUM_VN && vn_has[slot]) begin
      win_vn  = slot;              // Weighted network served
      win_hit = 1'b1;
    end else begin
      win_vn = rr_pick(NUM_VN, model_vn_last, 8'(vn_has));
    end
    vc     = rr_pick(NUM_VC, model_vc_last[win_vn], 8'(ch_has[win_vn * NUM_VC +: NUM_VC]));
    win_ch = win_vn * NUM_VC + vc;
    for (int p = 0; p < NUM_PORTS; p++) begin
      ports[p] = elig[p * NUM_CH + win_ch];
    end
    win_port = rr_pick(NUM_PORTS, model_port_last[win_ch], 8'(ports));
    win_own  = own[win_port * NUM_CH + win_ch];
    g[win_port * NUM_CH + win_ch] = 1'b1;
    return g;
  endfunction

  task automatic reset_model();
    model_wptr    = 0;
    model_vn_last = NUM_VN - 1;
    for (int c = 0; c < NUM_CH; c++) model_port_last[c] = NUM_PORTS - 1;
    for (int v = 0; v < NUM_VN; v++) model_vc_last[v] = NUM_VC - 1;
  endtask

  // --------------------------------------------------
  // Compare process, inputs and outputs are stable at the falling edge
  // --------------------------------------------------
  always @(negedge clk) begin : compare
    int   w_port;
    int   w_ch;
    int   w_vn;
    int   w_own;
    logic w_hit;
    if (primed) begin
      check_value(32'(grant), 32'(exp_grant), "grant");
      check_value(32'(vc_selected), 32'(exp_vc), "vc_selected");
    end
    if (rst_p) begin
      reset_model();
      exp_grant = '0;
      exp_vc    = '0;
    end else begin
      exp_grant = expected_grant(w_port, w_ch, w_vn, w_hit, w_own);
      if (exp_grant != '0) begin
        exp_vc                = ch_id_t'(w_own);
        model_port_last[w_ch] = w_port;
        model_vc_last[w_vn]   = w_ch % NUM_VC;
        if (!w_hit) model_vn_last = w_vn;   // Fallback pointer moves only on a miss
        model_wptr            = (model_wptr + 1) % WEIGHT_SLOTS;
      end
    end
    primed = 1'b1;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rst_p <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_p <= 1'b0;
  endtask

  task automatic settle();   // DUT takes the inputs, then outputs are read
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic randomize_inputs();
    req_id_t [NUM_CH-1:0] tab;
    req_id_t              cand;
    for (int c = 0; c < NUM_CH; c++) begin
      cand = req_id_t'($unsigned($random(seed)) % 32);
      for (int k = 0; k < c; k++) begin
        if (tab[k] == cand) cand = NO_OWNER;   // Keep owners unique
      end
      tab[c] = cand;
    end
    vc_owner <= tab;
    req_l    <= 6'($random(seed));
    req_n    <= 6'($random(seed));
    req_w    <= 6'($random(seed));
    req_s    <= 6'($random(seed));
    req_e    <= 6'($random(seed));
    stop_go  <= 6'($random(seed)) | 6'($random(seed));   // Mostly go
    go_phit  <= (($random(seed) & 7) != 0);
    weights  <= 20'($random(seed));
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : stimulus
    req_id_t [NUM_CH-1:0] tab;
    logic [WEIGHTS_W-1:0] wl;
    int                   prev;
    seed     = 32'h1cb789ab;
    rst_p    = 1'b1;
    {req_e, req_s, req_w, req_n, req_l} = '0;
    vc_owner = {NUM_CH{NO_OWNER}};
    stop_go  = '1;
    go_phit  = 1'b1;
    weights  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_p <= 1'b0;

    // Single request from S on slot 1, owns channel 3
    @(posedge clk);
    req_s    <= 6'b000010;
    vc_owner <= {NO_OWNER, NO_OWNER, req_id_t'(PORT_S * NUM_CH + 1), NO_OWNER,
                 NO_OWNER, NO_OWNER};
    settle();
    check_value(32'(grant), 32'h1 << (PORT_S * NUM_CH + 1), "single grant");
    check_value(32'(vc_selected), 32'd3, "single vc_selected");

    // Back-pressure and a channel-less request
    @(posedge clk);
    stop_go <= 6'b110111;
    settle();
    check_value(32'(grant), 32'h0, "grant with stop_go low");
    @(posedge clk);
    stop_go <= '1;
    go_phit <= 1'b0;
    settle();
    check_value(32'(grant), 32'h0, "grant with go_phit low");
    @(posedge clk);
    go_phit  <= 1'b1;
    vc_owner <= {NUM_CH{NO_OWNER}};
    settle();
    check_value(32'(grant), 32'h0, "grant without owned channel");
    check_value(32'(vc_selected), 32'd3, "held vc_selected");

    // All six channels owned by W, networks follow the weight list
    @(posedge clk);
    for (int c = 0; c < NUM_CH; c++) tab[c] = req_id_t'(PORT_W * NUM_CH + c);
    for (int k = 0; k < WEIGHT_SLOTS; k++) wl[2 * k +: 2] = 2'(slot_list[k]);
    vc_owner <= tab;
    req_w    <= '1;
    weights  <= wl;
    apply_reset();
    for (int k = 0; k < 2 * WEIGHT_SLOTS; k++) begin
      settle();
      check_value(32'(vc_selected / NUM_VC), 32'(slot_list[k % WEIGHT_SLOTS]),
                  "weighted network");
    end

    // Every slot names network 1, its two channels take turns
    @(posedge clk);
    weights <= {WEIGHT_SLOTS{2'd1}};
    settle();
    prev = int'(vc_selected);
    repeat (10) begin
      settle();
      check_value(32'(vc_selected), (prev == 2) ? 32'd3 : 32'd2, "network 1 channel");
      prev = int'(vc_selected);
    end

    // Network 0 idle, fallback alternates networks 1 and 2
    @(posedge clk);
    weights <= '0;
    req_w   <= 6'b111100;
    settle();
    prev = int'(vc_selected) / NUM_VC;
    repeat (10) begin
      settle();
      check_value(32'(vc_selected / NUM_VC), 32'(3 - prev), "fallback network");
      prev = int'(vc_selected) / NUM_VC;
    end

    repeat (RANDOM_CYCLES) begin
      @(posedge clk);
      randomize_inputs();
    end
    repeat (2) @(posedge clk);   // Last expectation is checked first
    $display("No errors");
    $finish;
  end

endmodule

//--- compile.f
noc_cfg_pkg.sv
sa_arb_pkg.sv
rr_arbiter.sv
request_filter.sv
port_stage.sv
vn_stage.sv
sa_vc_top.sv
tb_sa_vc.sv

//--- Makefile
TOP = tb_sa_vc

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
